//--- flitCrossbar.sv
`timescale 1ns/100ps

module flitCrossbar
  import nocFlitPkg::*;
  import nocRouterPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  flit_t               lFlit,
  input  flit_t               nFlit,
  input  flit_t               eFlit,
  input  flit_t               wFlit,
  input  flit_t               sFlit,
  input  logic [NumPorts-1:0] reqs,
  input  grantState_t         grant,
  output flit_t               outFlit,
  output logic                outValid,
  output logic [NumPorts-1:0] outPort
);

  logic [NumPorts-1:0]  hit;  // Granted and still requesting
  logic [FlitWidth-1:0] selFlit;

  assign hit = grant[NumPorts:1] & reqs;

  // AND-OR mux over a one-hot or zero hit
  assign selFlit = ({FlitWidth{hit[PortL]}} & lFlit)
                 | ({FlitWidth{hit[PortN]}} & nFlit)
                 | ({FlitWidth{hit[PortE]}} & eFlit)
                 | ({FlitWidth{hit[PortW]}} & wFlit)
                 | ({FlitWidth{hit[PortS]}} & sFlit);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outPort  <= '0;
    end
    else
    begin
      outValid <= |hit;
      outPort  <= hit;  // Source tag
    end
  end

  always_ff @(posedge clk)
  begin
    if (|hit)
      outFlit <= selFlit;
  end

  aPortTagOneHot: assert property (
    @(posedge clk) disable iff (rst)
    outValid |-> $onehot(outPort)
  );

endmodule

//--- nocFlitPkg.sv
package nocFlitPkg;

  localparam int FlitWidth   = 32;
  localparam int IdWidth     = 3;
  localparam int LengthWidth = 12;
  localparam int DestWidth   = 4;
  localparam int SpareWidth  = FlitWidth - IdWidth - LengthWidth - DestWidth;
  localparam int PayloadWidth = FlitWidth - IdWidth;

  typedef enum logic [IdWidth-1:0] {
    FlitIdle   = 3'd0,
    FlitHeader = 3'd1,
    FlitBody   = 3'd2,
    FlitTail   = 3'd3
  } flitId_t;

  // Header word carries the hold length for the arbiter
  typedef struct packed {
    flitId_t                id;
    logic [LengthWidth-1:0] length;
    logic [DestWidth-1:0]   dest;
    logic [SpareWidth-1:0]  spare;
  } flitHeader_t;

  typedef struct packed {
    flitId_t                 id;
    logic [PayloadWidth-1:0] payload;
  } flitBody_t;

  // Same id position in both views
  typedef union packed {
    flitHeader_t header;
    flitBody_t   body;
  } flit_t;

endpackage

//--- nocOutputPort.f
nocFlitPkg.sv
nocRouterPkg.sv
portTimer.sv
outputArbiter.sv
flitCrossbar.sv
nocOutputPort.sv
nocOutputPort_tb.sv

//--- nocOutputPort.sv
`timescale 1ns/100ps

module nocOutputPort
  import nocFlitPkg::*;
  import nocRouterPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  flit_t               lFlit,
  input  flit_t               nFlit,
  input  flit_t               eFlit,
  input  flit_t               wFlit,
  input  flit_t               sFlit,
  input  logic                lReq,
  input  logic                nReq,
  input  logic                eReq,
  input  logic                wReq,
  input  logic                sReq,
  output grantState_t         grant,
  output flit_t               outFlit,
  output logic                outValid,
  output logic [NumPorts-1:0] outPort
);

  logic [NumPorts-1:0] reqs;
  logic [NumPorts-1:0] timesUp;
  logic [NumPorts-1:0] run;
  logic                tL, tN, tE, tW, tS;
  logic                runL, runN, runE, runW, runS;

  assign reqs[PortL] = lReq;
  assign reqs[PortN] = nReq;
  assign reqs[PortE] = eReq;
  assign reqs[PortW] = wReq;
  assign reqs[PortS] = sReq;

  assign timesUp[PortL] = tL;
  assign timesUp[PortN] = tN;
  assign timesUp[PortE] = tE;
  assign timesUp[PortW] = tW;
  assign timesUp[PortS] = tS;

  assign runL = run[PortL];
  assign runN = run[PortN];
  assign runE = run[PortE];
  assign runW = run[PortW];
  assign runS = run[PortS];

  // One hold timer per input
  portTimer i_timerL (.clk(clk), .rst(rst), .flit(lFlit), .run(runL), .timesUp(tL));
  portTimer i_timerN (.clk(clk), .rst(rst), .flit(nFlit), .run(runN), .timesUp(tN));
  portTimer i_timerE (.clk(clk), .rst(rst), .flit(eFlit), .run(runE), .timesUp(tE));
  portTimer i_timerW (.clk(clk), .rst(rst), .flit(wFlit), .run(runW), .timesUp(tW));
  portTimer i_timerS (.clk(clk), .rst(rst), .flit(sFlit), .run(runS), .timesUp(tS));

  outputArbiter i_arbiter (
    .clk     (clk),
    .rst     (rst),
    .reqs    (reqs),
    .timesUp (timesUp),
    .grant   (grant),
    .run     (run)
  );

  flitCrossbar i_crossbar (
    .clk      (clk),
    .rst      (rst),
    .lFlit    (lFlit),
    .nFlit    (nFlit),
    .eFlit    (eFlit),
    .wFlit    (wFlit),
    .sFlit    (sFlit),
    .reqs     (reqs),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outPort  (outPort)
  );

endmodule

//--- nocOutputPort_tb.sv
`timescale 1ns/100ps

module nocOutputPort_tb
  import nocFlitPkg::*;
  import nocRouterPkg::*;
();

  localparam int DirectedCycles = 66;
  localparam int RandomCycles   = 600;
  localparam int CycleLimit     = 4 * (DirectedCycles + RandomCycles) + 200;

  logic                clk = 1'b0;
  logic                rst;
  logic [NumPorts-1:0] req;
  flit_t               flits [NumPorts];
  grantState_t         grant;
  flit_t               outFlit;
  logic                outValid;
  logic [NumPorts-1:0] outPort;

  int   remain [NumPorts];  // Packet cycles still to drive
  int   pktLen [NumPorts];
  logic fresh  [NumPorts];  // Next driven cycle is the header

  // Reference state from the cycle that just ended
  grantState_t         lastGrant;
  logic [NumPorts-1:0] lastReqs;
  flit_t               lastFlit;
  logic                lastHit;
  logic                quiet;  // No request seen since reset
  int                  holdLen;
  int                  expLimit [NumPorts];
  int                  cycleCount = 0;

  int                  curOwner;
  int                  lastOwner;
  logic                lastOwnerReq;
  int                  ownerLimit;
  int                  lastOwnerLimit;
  logic [NumPorts-1:0] lastPortBits;
  logic [NumPorts-1:0] expPort;
  grantState_t         expMove;

  always #2 clk = ~clk;

  nocOutputPort i_dut (
    .clk      (clk),
    .rst      (rst),
    .lFlit    (flits[PortL]),
    .nFlit    (flits[PortN]),
    .eFlit    (flits[PortE]),
    .wFlit    (flits[PortW]),
    .sFlit    (flits[PortS]),
    .lReq     (req[PortL]),
    .nReq     (req[PortN]),
    .eReq     (req[PortE]),
    .wReq     (req[PortW]),
    .sReq     (req[PortS]),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outPort  (outPort)
  );

  function automatic int ownerOf(input grantState_t g);
    case (g)
      GrantL:  return PortL;
      GrantN:  return PortN;
      GrantE:  return PortE;
      GrantW:  return PortW;
      GrantS:  return PortS;
      default: return -1;
    endcase
  endfunction

  // Next grant after leaving from under the rotation rule
  function automatic grantState_t expectedMove(input grantState_t from,
                                               input logic [NumPorts-1:0] r);
    grantState_t pick;
    int          owner;
    int          first;
    int          span;
    int          step;
    int          q;
    owner = ownerOf(from);
    pick  = GrantIdle;
    first = (owner < 0) ? PortL : owner + 1;
    span  = (owner < 0) ? NumPorts : NumPorts - 1;  // Owner itself never picked
    // Far end first so the nearest requester is written last
    for (step = span - 1; step >= 0; step--)
    begin
      q = (first + step) % NumPorts;
      if (r[q])
        pick = grantState_t'(6'b000010 << q);
    end
    return pick;
  endfunction

  function automatic flit_t makeHeader(input int len);
    flit_t f;
    f.header.id     = FlitHeader;
    f.header.length = LengthWidth'(len);
    f.header.dest   = DestWidth'($urandom);
    f.header.spare  = '0;
    return f;
  endfunction

  function automatic flit_t makeBody(input flitId_t id);
    flit_t f;
    f.body.id      = id;
    f.body.payload = PayloadWidth'($urandom);
    return f;
  endfunction

  function automatic logic portsBusy();
    int p;
    portsBusy = |req;
    for (p = 0; p < NumPorts; p++)
      if (remain[p] > 0)
        portsBusy = 1'b1;
  endfunction

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  // A port needs one quiet cycle between packets
  task automatic startPacket(input int p, input int len, input int dur);
    if (remain[p] == 0 && !req[p])
    begin
      pktLen[p] = len;
      remain[p] = dur;
      fresh[p]  = 1'b1;
    end
  endtask

  task automatic driveCycle();
    int p;
    @(posedge clk);
    #0.5;
    for (p = 0; p < NumPorts; p++)
    begin
      if (remain[p] > 0)
      begin
        req[p] = 1'b1;
        if (fresh[p])
          flits[p] = makeHeader(pktLen[p]);
        else if (remain[p] == 1)
          flits[p] = makeBody(FlitTail);
        else
          flits[p] = makeBody(FlitBody);
        fresh[p]  = 1'b0;
        remain[p] = remain[p] - 1;
      end
      else
      begin
        req[p]   = 1'b0;
        flits[p] = '0;
      end
    end
  endtask

  task automatic runCycles(input int n);
    repeat (n) driveCycle();
  endtask

  always_comb
  begin
    curOwner       = ownerOf(grant);
    lastOwner      = ownerOf(lastGrant);
    lastPortBits   = lastGrant[NumPorts:1];
    expPort        = lastHit ? lastPortBits : '0;
    lastOwnerReq   = 1'b0;
    ownerLimit     = 0;
    lastOwnerLimit = 0;
    if (curOwner >= 0)
      ownerLimit = expLimit[curOwner];
    if (lastOwner >= 0)
    begin
      lastOwnerReq   = lastReqs[lastOwner];
      lastOwnerLimit = expLimit[lastOwner];
    end
    expMove = expectedMove(lastGrant, lastReqs);
  end

  always @(posedge clk)
  begin : modelUpdate
    int k;
    if (rst)
    begin
      lastGrant <= GrantIdle;
      lastReqs  <= '0;
      lastFlit  <= '0;
      lastHit   <= 1'b0;
      quiet     <= 1'b1;
      holdLen   <= 0;
      for (k = 0; k < NumPorts; k++)
        expLimit[k] <= 0;
    end
    else
    begin
      lastGrant <= grant;
      lastReqs  <= req;
      holdLen   <= (grant == lastGrant) ? holdLen + 1 : 1;
      if (|req)
        quiet <= 1'b0;
      lastHit <= 1'b0;
      if (curOwner >= 0)
      begin
        lastHit  <= req[curOwner];
        lastFlit <= flits[curOwner];
      end
      for (k = 0; k < NumPorts; k++)
        if (flits[k].header.id == FlitHeader)
          expLimit[k] <= int'(flits[k].header.length);  // Header reloads the limit
    end
  end

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount > CycleLimit)
      reportFailure($sformatf("Timeout: run did not finish within %0d cycles", CycleLimit));
  end

  aIdleAfterReset: assert property (
    @(posedge clk) disable iff (rst)
    quiet |-> (grant == GrantIdle)
  ) else reportFailure($sformatf("Mismatch grant: expected 0x%h, got 0x%h",
                                 GrantIdle, $sampled(grant)));

  aNoValidAfterReset: assert property (
    @(posedge clk) disable iff (rst)
    quiet |-> !outValid
  ) else reportFailure($sformatf("Mismatch outValid: expected 0x0, got 0x%h",
                                 $sampled(outValid)));

  aHoldLength: assert property (
    @(posedge clk) disable iff (rst)
    (grant != lastGrant && lastOwner >= 0 && lastOwnerReq)
      |-> (holdLen == lastOwnerLimit + 1)
  ) else reportFailure($sformatf("Mismatch holdLen on port %0d: expected 0x%h, got 0x%h",
                                 $sampled(lastOwner), $sampled(lastOwnerLimit) + 1,
                                 $sampled(holdLen)));

  aHoldBound: assert property (
    @(posedge clk) disable iff (rst)
    (curOwner >= 0 && grant == lastGrant) |-> (holdLen <= ownerLimit)
  ) else reportFailure($sformatf("Port %0d kept the grant longer than its packet length",
                                 $sampled(curOwner)));

  aRotation: assert property (
    @(posedge clk) disable iff (rst)
    (lastGrant == GrantIdle || grant != lastGrant) |-> (grant == expMove)
  ) else reportFailure($sformatf("Mismatch grant: expected 0x%h, got 0x%h",
                                 $sampled(expMove), $sampled(grant)));

  aReleaseOnDrop: assert property (
    @(posedge clk) disable iff (rst)
    (lastOwner >= 0 && !lastOwnerReq) |-> (grant != lastGrant)
  ) else reportFailure($sformatf("Port %0d kept the grant after dropping its request",
                                 $sampled(lastOwner)));

  aOutValid: assert property (
    @(posedge clk) disable iff (rst)
    outValid == lastHit
  ) else reportFailure($sformatf("Mismatch outValid: expected 0x%h, got 0x%h",
                                 $sampled(lastHit), $sampled(outValid)));

  aOutPort: assert property (
    @(posedge clk) disable iff (rst)
    outPort == expPort
  ) else reportFailure($sformatf("Mismatch outPort: expected 0x%h, got 0x%h",
                                 $sampled(expPort), $sampled(outPort)));

  aOutFlit: assert property (
    @(posedge clk) disable iff (rst)
    lastHit |-> (outFlit == lastFlit)
  ) else reportFailure($sformatf("Mismatch outFlit: expected 0x%h, got 0x%h",
                                 $sampled(lastFlit), $sampled(outFlit)));

  initial
  begin
    int i;
    int p;
    void'($urandom(32'h9f0c6c51));
    rst = 1'b1;
    req = '0;
    for (p = 0; p < NumPorts; p++)
    begin
      flits[p]  = '0;
      remain[p] = 0;
      pktLen[p] = 0;
      fresh[p]  = 1'b0;
    end
    repeat (10) @(posedge clk);
    #0.5;
    rst = 1'b0;

    runCycles(3);
    startPacket(PortL, 3, 10);  // Lone port times out and passes idle before its regrant
    runCycles(12);
    startPacket(PortN, 0, 4);
    runCycles(6);
    startPacket(PortL, 2, 12);
    startPacket(PortE, 5, 12);
    startPacket(PortS, 1, 12);
    runCycles(14);
    startPacket(PortW, 6, 9);
    runCycles(10);
    startPacket(PortW, 2, 9);  // Shorter second header
    runCycles(11);
    startPacket(PortE, 7, 3);  // Drops before its hold ends
    startPacket(PortS, 4, 8);
    runCycles(10);

    for (i = 0; i < RandomCycles; i++)
    begin
      for (p = 0; p < NumPorts; p++)
        if ($urandom % 4 == 0)
          startPacket(p, $urandom % 8, 1 + $urandom % 14);
      driveCycle();
    end

    // Drain until the output goes quiet
    do
      driveCycle();
    while (portsBusy() || grant != GrantIdle || outValid);

    $display("Verification passed");
    $finish;
  end

endmodule

//--- nocRouterPkg.sv
package nocRouterPkg;

  localparam int NumPorts = 5;

  // Input port indices in rotation order
  localparam int PortL = 0;
  localparam int PortN = 1;
  localparam int PortE = 2;
  localparam int PortW = 3;
  localparam int PortS = 4;

  // One-hot grant state with idle in bit 0 and port i in bit i+1
  typedef enum logic [NumPorts:0] {
    GrantIdle = 6'b000001,
    GrantL    = 6'b000010,
    GrantN    = 6'b000100,
    GrantE    = 6'b001000,
    GrantW    = 6'b010000,
    GrantS    = 6'b100000
  } grantState_t;

endpackage

//--- outputArbiter.sv
`timescale 1ns/100ps

module outputArbiter
  import nocRouterPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [NumPorts-1:0] reqs,
  input  logic [NumPorts-1:0] timesUp,
  output grantState_t         grant,
  output logic [NumPorts-1:0] run
);

  grantState_t nextGrant;
  int          curPort;  // Port that owns the grant
  logic        holding;

  // First requester among span ports from port start with wraparound
  function automatic grantState_t rotatePick(
    input int                  start,
    input int                  span,
    input logic [NumPorts-1:0] req
  );
    grantState_t pick;
    logic        found;
    int          idx;
    int          k;
    pick  = GrantIdle;
    found = 1'b0;
    for (k = 0; k < NumPorts; k++)
    begin
      idx = (start + k) % NumPorts;
      if (!found && (k < span) && req[idx])
      begin
        pick  = grantState_t'((NumPorts + 1)'(1) << (idx + 1));
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  // Grant state to port index
  always_comb
  begin
    holding = 1'b1;
    curPort = PortL;
    case (grant)
      GrantL:  curPort = PortL;
      GrantN:  curPort = PortN;
      GrantE:  curPort = PortE;
      GrantW:  curPort = PortW;
      GrantS:  curPort = PortS;
      default: holding = 1'b0;  // Idle
    endcase
  end

  always_comb
  begin
    run = '0;
    if (!holding)
      nextGrant = rotatePick(PortL, NumPorts, reqs);  // Fixed order from idle
    else if (reqs[curPort] && !timesUp[curPort])
    begin
      run[curPort] = 1'b1;
      nextGrant    = grant;
    end
    else
    begin
      // Current port left out so a lone timed-out port sees idle first
      nextGrant = rotatePick(curPort + 1, NumPorts - 1, reqs);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= GrantIdle;
    else
      grant <= nextGrant;
  end

  aGrantOneHot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot(grant)
  );

endmodule

//--- portTimer.sv
`timescale 1ns/100ps

module portTimer
  import nocFlitPkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  flit_t flit,
  input  logic  run,
  output logic  timesUp
);

  logic [LengthWidth-1:0] limit;  // Length of last header seen
  logic [LengthWidth-1:0] count;  // Cycles held so far

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flit.header.id == FlitHeader)
        limit <= flit.header.length;  // Any header reloads
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  // Hold ends once count reaches the header length
  assign timesUp = (count == limit);

  // Arbiter must release run before the count passes the limit
  aCountInRange: assert property (
    @(posedge clk) disable iff (rst)
    run |-> (count <= limit)
  );

endmodule

//--- run.sh
#!/bin/sh
# Build the nocOutputPort testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module nocOutputPort_tb \
  -f nocOutputPort.f -o simv > build.log 2>&1 \
  && ./obj_dir/simv 2>&1 | tee sim.log \
  && grep -q "Verification passed" sim.log \
  && ! grep -q "Verification failed" sim.log \
  && echo "Run passed" \
  || { echo "Run failed, see build.log and sim.log"; exit 1; }
